// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_width_down
FILELIST = width_down_top.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_checker.sv
module tb_checker
   import fifo_cfg_pkg::*;
   import credit_pkg::*;
(
   input logic                clk_i,
   input logic                arst_n_i,
   input logic                w_en_i,
   input logic [W_DATA_W-1:0] w_data_i,
   input logic                w_full_i,
   input logic                out_valid_i,
   input logic [R_DATA_W-1:0] out_data_i,
   input logic                credit_return_i,
   input logic [ADDR_W:0]     level_i,
   input logic [1:0]          exp_full_i   // 2 means no check
);

   logic [R_DATA_W-1:0] byte_q [$];
   logic write_pending;
   int   acc_words;
   int   pops;
   int   outstanding;
   int   chk_order, err_order;
   int   chk_credit, err_credit;
   int   chk_full, err_full;
   int   chk_level, err_level;
   int   chk_drain, err_drain;

   // sampled on the falling edge, away from the drive edge
   always @(negedge clk_i or negedge arst_n_i) begin : compare
      logic [R_DATA_W-1:0] exp_byte;
      int exp_level;
      if (!arst_n_i) begin
         byte_q.delete();
         write_pending = 1'b0;
         acc_words     = 0;
         pops          = 0;
         outstanding   = 0;
      end else begin
         if (write_pending) acc_words++; // taken at the last rising edge
         if (out_valid_i) begin
            chk_order++;
            pops++;
            outstanding++;
            if (byte_q.size() == 0) begin
               err_order++;
               $display("output byte %h appeared with no word written", out_data_i);
            end else begin
               exp_byte = byte_q.pop_front();
               if (out_data_i !== exp_byte) begin
                  err_order++;
                  $display("ERR out_data_o expected %h got %h", exp_byte, out_data_i);
               end
            end
         end
         if (credit_return_i) begin
            if (outstanding == 0) begin
               err_credit++;
               $display("credit returned while no byte was outstanding");
            end else begin
               outstanding--;
            end
         end
         chk_credit++;
         if (outstanding > CREDIT_MAX) begin
            err_credit++;
            $display("credit limit broken, %0d bytes outstanding", outstanding);
         end
         exp_level = RATIO * acc_words - pops;
         chk_level++;
         if (int'(level_i) != exp_level) begin
            err_level++;
            $display("ERR level_o expected %h got %h", exp_level, level_i);
         end
         if (exp_full_i != 2'd2) begin
            chk_full++;
            if (w_full_i !== exp_full_i[0]) begin
               err_full++;
               $display("ERR w_full_o expected %h got %h", exp_full_i[0], w_full_i);
            end
         end
         write_pending = w_en_i && !w_full_i;
         if (write_pending) begin
            for (int i = 0; i < RATIO; i++) begin
               byte_q.push_back(w_data_i[i*R_DATA_W +: R_DATA_W]); // low byte first
            end
         end
      end
   end

   task automatic summarize(output int errors);
      chk_drain = 4;
      if (byte_q.size() != 0) begin
         err_drain++;
         $display("%0d bytes never reached the output", byte_q.size());
      end
      if (level_i != '0) begin
         err_drain++;
         $display("ERR level_o expected %h got %h", 0, level_i);
      end
      if (out_valid_i !== 1'b0) begin
         err_drain++;
         $display("ERR out_valid_o expected %h got %h", 1'b0, out_valid_i);
      end
      if (outstanding != 0) begin
         err_drain++;
         $display("%0d credits not returned at the end", outstanding);
      end
      $display("byte order   : %0d checks, %0d errors", chk_order, err_order);
      $display("credit limit : %0d checks, %0d errors", chk_credit, err_credit);
      $display("full flag    : %0d checks, %0d errors", chk_full, err_full);
      $display("level        : %0d checks, %0d errors", chk_level, err_level);
      $display("drain        : %0d checks, %0d errors", chk_drain, err_drain);
      errors = err_order + err_credit + err_full + err_level + err_drain;
      $display("total: %0d checks, %0d errors",
               chk_order + chk_credit + chk_full + chk_level + chk_drain, errors);
   endtask

endmodule

// File: sim/tb_width_down.sv
module tb_width_down
   import fifo_cfg_pkg::*;
;

   logic                clk;
   logic                arst_n;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                w_full;
   logic                out_valid;
   logic [R_DATA_W-1:0] out_data;
   logic                credit_return;
   logic [ADDR_W:0]     level;
   logic [1:0]          exp_full;

   logic [7:0]          op_q [$];
   logic [W_DATA_W-1:0] data_q [$];
   int                  cnt_q [$];
   int                  ef_q [$];
   logic                trace_ready;
   longint              watch_limit;

   width_down_top u_dut (
      .clk_i           (clk),
      .arst_n_i        (arst_n),
      .w_en_i          (w_en),
      .w_data_i        (w_data),
      .w_full_o        (w_full),
      .out_valid_o     (out_valid),
      .out_data_o      (out_data),
      .credit_return_i (credit_return),
      .level_o         (level)
   );

   tb_checker u_chk (
      .clk_i           (clk),
      .arst_n_i        (arst_n),
      .w_en_i          (w_en),
      .w_data_i        (w_data),
      .w_full_i        (w_full),
      .out_valid_i     (out_valid),
      .out_data_i      (out_data),
      .credit_return_i (credit_return),
      .level_i         (level),
      .exp_full_i      (exp_full)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic drive_cycle(input logic we, input logic [W_DATA_W-1:0] d,
                              input logic cr, input logic [1:0] ef);
      @(posedge clk);
      w_en          <= we;
      w_data        <= d;
      credit_return <= cr;
      exp_full      <= ef;
   endtask

   initial begin
      wait (trace_ready);
      #(watch_limit);
      $display("timeout: trace did not finish within %0d time units", watch_limit);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      int    fd;
      int    code;
      int    n;
      int    ef;
      int    gap;
      int    errs;
      int    seed;
      longint cycles;
      string line;
      logic [7:0] op;
      logic [W_DATA_W-1:0] d;
      arst_n        = 1'b0;
      w_en          = 1'b0;
      w_data        = '0;
      credit_return = 1'b0;
      exp_full      = 2'd2;
      trace_ready   = 1'b0;
      watch_limit   = 0;
      seed          = 56456;
      cycles        = 0;
      fd = $fopen("sim/width_down_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file");
         $display("TEST FAIL");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
               code = $sscanf(line, "%c %h %d %d", op, d, n, ef);
               if (code == 4) begin
                  op_q.push_back(op);
                  data_q.push_back(d);
                  cnt_q.push_back(n);
                  ef_q.push_back(ef);
                  cycles += n + 2; // gaps are at most two cycles
               end
            end
         end
         $fclose(fd);
         watch_limit = (cycles + 200) * 100;
         trace_ready = 1'b1;

         repeat (2) @(posedge clk);
         arst_n <= 1'b1;

         foreach (op_q[i]) begin
            for (int k = 0; k < cnt_q[i]; k++) begin
               case (op_q[i])
                  "W":     drive_cycle(1'b1, data_q[i] + 32'(k), 1'b0, 2'(ef_q[i]));
                  "B":     drive_cycle(1'b1, data_q[i], 1'b0, 2'(ef_q[i]));
                  "C":     drive_cycle(1'b0, '0, 1'b1, 2'(ef_q[i]));
                  default: drive_cycle(1'b0, '0, 1'b0, 2'(ef_q[i]));
               endcase
            end
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) drive_cycle(1'b0, '0, 1'b0, 2'd2);
         end
         repeat (4) drive_cycle(1'b0, '0, 1'b0, 2'd2);
         @(posedge clk); // last falling edge sample is done
         u_chk.summarize(errs);
         if (errs == 0) begin
            $display("TEST PASS");
         end else begin
            $display("TEST FAIL");
         end
         $finish;
      end
   end

endmodule

// File: sim/width_down_assertions.sv
module width_down_assertions
   import credit_pkg::*;
#(
   parameter bit FIFO_SIDE = 1'b1 // FIFO flags, else the credit counter
) (
   input logic    clk_i,
   input logic    arst_n_i,
   input logic    full_i,
   input logic    empty_i,
   input logic    pop_i,
   input credit_t credit_i
);

   if (FIFO_SIDE) begin : g_fifo
      a_full_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         !(full_i && empty_i))
         else $error("full and empty flags high together");

      a_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         !(pop_i && empty_i))
         else $error("read request while FIFO empty");
   end else begin : g_tx
      a_credit_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         credit_i <= credit_t'(CREDIT_MAX))
         else $error("credit count above its maximum");
   end

endmodule

bind iob_fifo_sync width_down_assertions #(.FIFO_SIDE(1'b1)) u_fifo_assert (
   .clk_i    (clk_i),
   .arst_n_i (arst_n_i),
   .full_i   (w_full_o),
   .empty_i  (r_empty_o),
   .pop_i    (r_en_i),
   .credit_i ()
);

bind credit_tx width_down_assertions #(.FIFO_SIDE(1'b0)) u_tx_assert (
   .clk_i    (clk_i),
   .arst_n_i (arst_n_i),
   .full_i   (),
   .empty_i  (),
   .pop_i    (),
   .credit_i (credit_q)
);

// File: sim/width_down_trace.txt
# op data count exp_full, one cycle per count
# op W write, B write while full, C credit return, I idle; exp_full 2 means unchecked
W 11223344 1 0
W a5b6c7d8 1 0
I 0 6 2
C 0 4 2
I 0 3 2
C 0 4 2
I 0 2 2
W 03020100 17 0
I 0 2 2
B deadbeef 2 1
I 0 1 2
C 0 68 2
I 0 6 2

// File: src/credit_pkg.sv
package credit_pkg;

   // consumer buffer depth, also the credit count out of reset
   localparam int CREDIT_MAX = 4;

   // must hold 0 up to CREDIT_MAX
   localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

   typedef logic [CREDIT_W-1:0] credit_t;

endpackage

// File: src/credit_tx.sv
module credit_tx
   import credit_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,

   // FIFO read side
   input  logic       fifo_empty_i,
   input  logic [7:0] fifo_data_i,
   output logic       fifo_r_en_o,

   // consumer link
   input  logic       credit_return_i,
   output logic       out_valid_o,
   output logic [7:0] out_data_o
);

   credit_t credit_q;
   logic    have_credit;

   // a return in this cycle already counts
   assign have_credit = (credit_q != '0) | credit_return_i;
   assign fifo_r_en_o = ~fifo_empty_i & have_credit;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credit_q <= credit_t'(CREDIT_MAX);
      end else begin
         case ({credit_return_i, fifo_r_en_o})
            2'b10:   credit_q <= credit_q + credit_t'(1);
            2'b01:   credit_q <= credit_q - credit_t'(1);
            default: credit_q <= credit_q; // none, or return and pop cancel
         endcase
      end
   end

   // byte shows up one cycle after the pop
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= fifo_r_en_o;
      end
   end

   assign out_data_o = fifo_data_i; // converter output is registered already

endmodule

// File: src/ext_mem_if.sv
interface ext_mem_if
   import fifo_cfg_pkg::*;
();

   // write port, one wide word per access
   logic                w_en;
   logic [W_ADDR_W-1:0] w_addr;
   logic [W_DATA_W-1:0] w_data;

   // read port, registered inside the RAM
   logic                r_en;
   logic [W_ADDR_W-1:0] r_addr;
   logic [W_DATA_W-1:0] r_data;

   modport conv (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

// File: src/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // data widths on each side
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // narrow side addressing, in bytes
   localparam int ADDR_W = 6;

   localparam int RATIO       = W_DATA_W / R_DATA_W; // bytes per word
   localparam int ADDR_W_DIFF = $clog2(RATIO);

   localparam int W_ADDR_W = ADDR_W - ADDR_W_DIFF; // wide side, RAM words
   localparam int R_ADDR_W = ADDR_W;

   // level steps per access, counted in bytes
   localparam logic [ADDR_W:0] W_INCR = (ADDR_W + 1)'(RATIO);
   localparam logic [ADDR_W:0] R_INCR = (ADDR_W + 1)'(1);

   localparam logic [ADDR_W:0] FIFO_SIZE = {1'b1, {ADDR_W{1'b0}}};

endpackage

// File: src/iob_asym_converter.sv
module iob_asym_converter
   import fifo_cfg_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   // wide write side
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,

   // narrow read side
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,

   ext_mem_if.conv             mem
);

   logic [ADDR_W_DIFF-1:0] lane_sel_q;
   logic [R_DATA_W-1:0]    lane [RATIO];

   // writes are already word sized
   assign mem.w_en   = w_en_i;
   assign mem.w_addr = w_addr_i;
   assign mem.w_data = w_data_i;

   // byte address -> word address
   assign mem.r_en   = r_en_i;
   assign mem.r_addr = r_addr_i[R_ADDR_W-1:ADDR_W_DIFF];

   // lane index follows the RAM read by one cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_sel_q <= '0;
      end else if (r_en_i) begin
         lane_sel_q <= r_addr_i[ADDR_W_DIFF-1:0];
      end
   end

   // lane 0 is the least significant byte
   for (genvar i = 0; i < RATIO; i++) begin : g_lane
      assign lane[i] = mem.r_data[i*R_DATA_W +: R_DATA_W];
   end

   assign r_data_o = lane[lane_sel_q];

endmodule

// File: src/iob_fifo_sync.sv
module iob_fifo_sync
   import fifo_cfg_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   // write side
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,

   // read side
   input  logic                r_en_i,
   output logic                r_empty_o,
   output logic [R_DATA_W-1:0] r_data_o,

   output logic [ADDR_W:0]     level_o,

   ext_mem_if.conv             mem
);

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     level_q;
   logic [ADDR_W:0]     level_nxt;

   // accesses that actually happen
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   // address counters, wrap naturally
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_addr <= '0;
         r_addr <= '0;
      end else begin
         if (w_en_int) w_addr <= w_addr + W_ADDR_W'(1);
         if (r_en_int) r_addr <= r_addr + R_ADDR_W'(1);
      end
   end

   always_comb begin
      level_nxt = level_q;
      if (w_en_int) level_nxt = level_nxt + W_INCR;
      if (r_en_int) level_nxt = level_nxt - R_INCR;
   end

   // level and flags all move on the same edge
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= level_nxt < R_INCR;
         w_full_o  <= level_nxt > (FIFO_SIZE - W_INCR); // no room for a full word
      end
   end

   assign level_o = level_q;

   iob_asym_converter u_asym_converter (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_addr),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_addr),
      .r_data_o (r_data_o),
      .mem      (mem)
   );

endmodule

// File: src/iob_ram_2p.sv
module iob_ram_2p
   import fifo_cfg_pkg::*;
(
   input logic   clk_i,
   ext_mem_if.mem mem
);

   localparam int DEPTH = 2 ** W_ADDR_W;

   logic [W_DATA_W-1:0] ram [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (mem.w_en) begin
         ram[mem.w_addr] <= mem.w_data;
      end
   end

   // read port, output held between reads
   always_ff @(posedge clk_i) begin
      if (mem.r_en) begin
         mem.r_data <= ram[mem.r_addr];
      end
   end

endmodule

// File: src/width_down_top.sv
module width_down_top
   import fifo_cfg_pkg::*;
(
   input  logic                clk_i,
   input  logic                arst_n_i,

   // producer
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,

   // consumer
   output logic                out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o,
   input  logic                credit_return_i,

   output logic [ADDR_W:0]     level_o
);

   logic                fifo_r_en;
   logic                fifo_empty;
   logic [R_DATA_W-1:0] fifo_data;

   ext_mem_if u_mem_if ();

   iob_fifo_sync u_fifo (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (fifo_r_en),
      .r_empty_o (fifo_empty),
      .r_data_o  (fifo_data),
      .level_o   (level_o),
      .mem       (u_mem_if.conv)
   );

   iob_ram_2p u_ram (
      .clk_i (clk_i),
      .mem   (u_mem_if.mem)
   );

   credit_tx u_credit_tx (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .fifo_empty_i    (fifo_empty),
      .fifo_data_i     (fifo_data),
      .fifo_r_en_o     (fifo_r_en),
      .credit_return_i (credit_return_i),
      .out_valid_o     (out_valid_o),
      .out_data_o      (out_data_o)
   );

endmodule

// File: width_down_top.f
src/fifo_cfg_pkg.sv
src/credit_pkg.sv
src/ext_mem_if.sv
src/iob_ram_2p.sv
src/iob_asym_converter.sv
src/iob_fifo_sync.sv
src/credit_tx.sv
src/width_down_top.sv
sim/width_down_assertions.sv
sim/tb_checker.sv
sim/tb_width_down.sv
